//--- logic/llc_tag_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llc tag store package
// cache geometry, tag entry layout and
// the march x state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package llc_tag_pkg;

  // number of ways in the set-associative store
  localparam int unsigned NumWays = 4;
  // set index width and resulting set count
  localparam int unsigned IndexLength = 5;
  localparam int unsigned NumSets = 2 ** IndexLength;
  // width of the stored tag field
  localparam int unsigned TagLength = 10;

  // one bit per way, bit position is the way number
  typedef logic [NumWays-1:0] way_ind_t;

  // set index (macro address)
  typedef logic [IndexLength-1:0] index_t;

  // one tag entry as held in a way
  typedef struct packed {
    // entry valid
    logic val;
    // line dirty
    logic dit;
    // stored tag
    logic [TagLength-1:0] tag;
  } tag_t;

  // march x steps, in execution order
  typedef enum logic [3:0] {
    WZEROUP,
    RZEROUP,
    WONEUP,
    RONEDOWN,
    WZERODOWN,
    RZERODOWN,
    BISTEND
  } bist_e;

endpackage

//--- logic/llc_index_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// set index counter
// up/down by one, with clear and load,
// flags the wrap one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module llc_index_counter import llc_tag_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   clear_i,
  input  logic   en_i,
  input  logic   load_i,
  input  logic   down_i,
  input  index_t d_i,
  output index_t q_o,
  output logic   overflow_o
);

  index_t cnt_q;
  logic   ovf_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      ovf_q <= 1'b0;
    end else if (clear_i) begin
      // clear wins over everything else
      cnt_q <= '0;
      ovf_q <= 1'b0;
    end else if (load_i) begin
      cnt_q <= d_i;
      ovf_q <= 1'b0;
    end else if (en_i) begin
      if (down_i) begin
        cnt_q <= cnt_q - index_t'(1);
        // leaving zero downwards wraps to the top
        ovf_q <= (cnt_q == '0);
      end else begin
        cnt_q <= cnt_q + index_t'(1);
        // leaving the top wraps to zero
        ovf_q <= (cnt_q == '1);
      end
    end else begin
      // flag lasts a single cycle
      ovf_q <= 1'b0;
    end
  end

  assign q_o        = cnt_q;
  assign overflow_o = ovf_q;

  // the controller never asks for both at once
  a_no_clear_and_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(clear_i && load_i));

endmodule

//--- logic/llc_tag_bist_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag memory self test controller
// runs march x over all sets of all ways,
// leaves every entry at zero and
// collects the per-way pass flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module llc_tag_bist_ctrl import llc_tag_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // start strobe and idle level
  input  logic     valid_i,
  output logic     ready_o,
  output logic     busy_o,
  // index counter
  input  index_t   index_i,
  input  logic     overflow_i,
  output logic     clear_cnt_o,
  output logic     en_cnt_o,
  output logic     load_cnt_o,
  output logic     down_cnt_o,
  output index_t   cnt_val_o,
  // tag memory access
  output logic     req_o,
  output logic     we_o,
  output tag_t     pattern_o,
  // checker flags and aggregated result
  input  way_ind_t bist_res_i,
  input  logic     bist_res_valid_i,
  output way_ind_t bist_res_o,
  output logic     eoc_o
);

  logic     busy_q, busy_d;
  bist_e    bist_q, bist_d;
  way_ind_t res_q, res_d;
  // set in the phases that read back
  logic     read_phase;
  // set in the phases that count down
  logic     down_phase;

  assign read_phase = (bist_q == RZEROUP) || (bist_q == RONEDOWN) || (bist_q == RZERODOWN);
  assign down_phase = (bist_q == RONEDOWN) || (bist_q == WZERODOWN) || (bist_q == RZERODOWN);

  always_comb begin
    busy_d      = busy_q;
    bist_d      = bist_q;
    res_d       = res_q;
    ready_o     = 1'b0;
    req_o       = 1'b0;
    we_o        = 1'b0;
    eoc_o       = 1'b0;
    clear_cnt_o = 1'b0;
    en_cnt_o    = 1'b0;
    load_cnt_o  = 1'b0;
    down_cnt_o  = 1'b0;
    cnt_val_o   = '0;
    pattern_o   = '0;

    if (busy_q) begin
      // overflow cycle is idle, only prepare the next pass
      if (overflow_i) begin
        case (bist_q)
          WZEROUP:   clear_cnt_o = 1'b1;
          RZEROUP:   clear_cnt_o = 1'b1;
          RZERODOWN: clear_cnt_o = 1'b1;
          default: begin
            // next pass counts down from the top set
            load_cnt_o = 1'b1;
            cnt_val_o  = '1;
          end
        endcase
        bist_d = (bist_q == RZERODOWN) ? BISTEND : bist_e'(bist_q + 4'd1);
      end else if (bist_q == BISTEND) begin
        eoc_o  = 1'b1;
        busy_d = 1'b0;
        bist_d = WZEROUP;
      end else begin
        req_o      = 1'b1;
        en_cnt_o   = 1'b1;
        down_cnt_o = down_phase;
        we_o       = !read_phase;
        // ones for the write-up and the following read-down pass
        if ((bist_q == WONEUP) || (bist_q == RONEDOWN)) begin
          pattern_o = '1;
        end
      end
      // a zero flag from any way sticks in the result
      if (read_phase && bist_res_valid_i) begin
        res_d = res_q & bist_res_i;
      end
    end else begin
      ready_o = 1'b1;
      if (valid_i) begin
        busy_d      = 1'b1;
        bist_d      = WZEROUP;
        clear_cnt_o = 1'b1;
        // fresh result for this run
        res_d       = '1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      bist_q <= WZEROUP;
      res_q  <= '1;
    end else begin
      busy_q <= busy_d;
      bist_q <= bist_d;
      res_q  <= res_d;
    end
  end

  assign busy_o     = busy_q;
  assign bist_res_o = res_q;

  // end pulse only in the final state and with the counter back on set zero
  a_eoc_in_end: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    eoc_o |-> (bist_q == BISTEND) && (index_i == '0));

  // after a wrap the counter sits on the first set of the direction just used
  a_wrap_index: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (busy_q && overflow_i) |-> (index_i == (down_phase ? index_t'('1) : index_t'('0))));

endmodule

//--- logic/llc_tag_sram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-port memory of one way
// one entry per set, read data
// registered one cycle after request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module llc_tag_sram import llc_tag_pkg::*; #(
  // stored payload
  parameter type data_t = logic
) (
  input  logic   clk_i,
  input  logic   req_i,
  input  logic   we_i,
  input  index_t index_i,
  input  data_t  wdata_i,
  output data_t  rdata_o
);

  data_t mem [NumSets];
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[index_i] <= wdata_i;
      end else begin
        // read port only updates on a read
        rdata_q <= mem[index_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- logic/llc_tag_port_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag memory port mux
// self test owns all ways while busy,
// otherwise functional writes and lookups
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module llc_tag_port_mux import llc_tag_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     busy_i,
  // self test side
  input  logic     bist_req_i,
  input  logic     bist_we_i,
  input  index_t   bist_index_i,
  input  tag_t     bist_pattern_i,
  // functional write
  input  logic     wr_req_i,
  input  way_ind_t wr_way_i,
  input  index_t   wr_index_i,
  input  tag_t     wr_tag_i,
  // functional lookup
  input  logic     lk_req_i,
  input  index_t   lk_index_i,
  // per-way memory ports
  output way_ind_t way_req_o,
  output way_ind_t way_we_o,
  output index_t   way_index_o [NumWays],
  output tag_t     way_wdata_o [NumWays],
  output logic     lk_issued_o,
  output logic     func_ready_o
);

  logic lk_issued_q;

  always_comb begin
    for (int unsigned w = 0; w < NumWays; w++) begin
      if (busy_i) begin
        // all ways step through the test together
        way_req_o[w]   = bist_req_i;
        way_we_o[w]    = bist_we_i;
        way_index_o[w] = bist_index_i;
        way_wdata_o[w] = bist_pattern_i;
      end else if (wr_req_i && wr_way_i[w]) begin
        // write goes only to the selected way
        way_req_o[w]   = 1'b1;
        way_we_o[w]    = 1'b1;
        way_index_o[w] = wr_index_i;
        way_wdata_o[w] = wr_tag_i;
      end else begin
        // lookup reads every remaining way
        way_req_o[w]   = lk_req_i;
        way_we_o[w]    = 1'b0;
        way_index_o[w] = lk_index_i;
        way_wdata_o[w] = wr_tag_i;
      end
    end
  end

  // read data of an accepted lookup shows up next cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lk_issued_q <= 1'b0;
    end else begin
      lk_issued_q <= lk_req_i && !busy_i;
    end
  end

  assign lk_issued_o  = lk_issued_q;
  assign func_ready_o = !busy_i;

  // a write targets at most one way
  a_wr_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_req_i |-> $onehot0(wr_way_i));

endmodule

//--- logic/llc_tag_read_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// self test readback checker
// compares each way's read data with
// the pattern expected one cycle earlier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module llc_tag_read_check import llc_tag_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     rd_i,
  input  tag_t     expect_i,
  input  tag_t     way_rdata_i [NumWays],
  output way_ind_t res_o,
  output logic     res_valid_o
);

  logic rd_q;
  tag_t expect_q;

  // line up strobe and pattern with the memory read latency
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= rd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    expect_q <= expect_i;
  end

  always_comb begin
    for (int unsigned w = 0; w < NumWays; w++) begin
      // set when the way returned exactly the pattern
      res_o[w] = (way_rdata_i[w] == expect_q);
    end
  end

  assign res_valid_o = rd_q;

endmodule

//--- logic/llc_tag_lookup.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tag lookup stage
// matches the lookup tag against all
// ways and registers hits and dirty flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module llc_tag_lookup import llc_tag_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 issued_i,
  input  logic [TagLength-1:0] tag_i,
  input  tag_t                 way_rdata_i [NumWays],
  output logic                 valid_o,
  output way_ind_t             hit_o,
  output logic                 dirty_o
);

  logic [TagLength-1:0] tag_q;
  way_ind_t             hit_d, hit_q;
  logic                 dirty_d, dirty_q;
  logic                 valid_q;

  // tag waits for the memory read
  always_ff @(posedge clk_i) begin
    tag_q <= tag_i;
  end

  always_comb begin
    dirty_d = 1'b0;
    for (int unsigned w = 0; w < NumWays; w++) begin
      // invalid entries never hit
      hit_d[w] = way_rdata_i[w].val && (way_rdata_i[w].tag == tag_q);
      dirty_d  = dirty_d | (hit_d[w] & way_rdata_i[w].dit);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issued_i;
    end
  end

  // result registers only load for a real lookup
  always_ff @(posedge clk_i) begin
    if (issued_i) begin
      hit_q   <= hit_d;
      dirty_q <= dirty_d;
    end
  end

  assign valid_o = valid_q;
  assign hit_o   = hit_q;
  assign dirty_o = dirty_q;

  // a tag lives in at most one way of a set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> $onehot0(hit_o));

endmodule

//--- logic/llc_tag_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llc tag store top
// self test controller, index counter,
// way memories, port mux, checker, lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module llc_tag_store import llc_tag_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // self test
  input  logic                 bist_valid_i,
  output logic                 bist_ready_o,
  output way_ind_t             bist_res_o,
  output logic                 bist_eoc_o,
  // functional write
  input  logic                 wr_req_i,
  input  way_ind_t             wr_way_i,
  input  index_t               wr_index_i,
  input  tag_t                 wr_tag_i,
  // functional lookup
  input  logic                 lk_req_i,
  input  index_t               lk_index_i,
  input  logic [TagLength-1:0] lk_tag_i,
  output logic                 lk_valid_o,
  output way_ind_t             lk_hit_o,
  output logic                 lk_dirty_o,
  output logic                 func_ready_o
);

  // controller to counter
  logic     clear_cnt, en_cnt, load_cnt, down_cnt, overflow;
  index_t   load_val, index;
  // controller to mux and checker
  logic     bist_req, bist_we, busy, bist_rd;
  tag_t     bist_pattern;
  way_ind_t bist_res;
  logic     bist_res_valid;
  // mux to memories
  way_ind_t way_req, way_we;
  index_t   way_index [NumWays];
  tag_t     way_wdata [NumWays];
  tag_t     way_rdata [NumWays];
  logic     lk_issued;

  // only read passes are checked
  assign bist_rd = bist_req & ~bist_we;

  llc_tag_bist_ctrl u_bist_ctrl (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .valid_i          (bist_valid_i),
    .ready_o          (bist_ready_o),
    .busy_o           (busy),
    .index_i          (index),
    .overflow_i       (overflow),
    .clear_cnt_o      (clear_cnt),
    .en_cnt_o         (en_cnt),
    .load_cnt_o       (load_cnt),
    .down_cnt_o       (down_cnt),
    .cnt_val_o        (load_val),
    .req_o            (bist_req),
    .we_o             (bist_we),
    .pattern_o        (bist_pattern),
    .bist_res_i       (bist_res),
    .bist_res_valid_i (bist_res_valid),
    .bist_res_o       (bist_res_o),
    .eoc_o            (bist_eoc_o)
  );

  llc_index_counter u_index_cnt (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .clear_i    (clear_cnt),
    .en_i       (en_cnt),
    .load_i     (load_cnt),
    .down_i     (down_cnt),
    .d_i        (load_val),
    .q_o        (index),
    .overflow_o (overflow)
  );

  llc_tag_port_mux u_port_mux (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .busy_i         (busy),
    .bist_req_i     (bist_req),
    .bist_we_i      (bist_we),
    .bist_index_i   (index),
    .bist_pattern_i (bist_pattern),
    .wr_req_i       (wr_req_i),
    .wr_way_i       (wr_way_i),
    .wr_index_i     (wr_index_i),
    .wr_tag_i       (wr_tag_i),
    .lk_req_i       (lk_req_i),
    .lk_index_i     (lk_index_i),
    .way_req_o      (way_req),
    .way_we_o       (way_we),
    .way_index_o    (way_index),
    .way_wdata_o    (way_wdata),
    .lk_issued_o    (lk_issued),
    .func_ready_o   (func_ready_o)
  );

  // one memory per way
  for (genvar w = 0; w < NumWays; w++) begin : g_way
    llc_tag_sram #(
      .data_t (tag_t)
    ) u_sram (
      .clk_i   (clk_i),
      .req_i   (way_req[w]),
      .we_i    (way_we[w]),
      .index_i (way_index[w]),
      .wdata_i (way_wdata[w]),
      .rdata_o (way_rdata[w])
    );
  end

  llc_tag_read_check u_read_check (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_i        (bist_rd),
    .expect_i    (bist_pattern),
    .way_rdata_i (way_rdata),
    .res_o       (bist_res),
    .res_valid_o (bist_res_valid)
  );

  llc_tag_lookup u_lookup (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .issued_i    (lk_issued),
    .tag_i       (lk_tag_i),
    .way_rdata_i (way_rdata),
    .valid_o     (lk_valid_o),
    .hit_o       (lk_hit_o),
    .dirty_o     (lk_dirty_o)
  );

endmodule

//--- sim/tb_llc_tag_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llc tag store testbench
// replays the stimulus file, runs self tests,
// writes and lookups, and checks every result
// against a reference array of entries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_llc_tag_store import llc_tag_pkg::*; ();

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 bist_valid_i;
  logic                 bist_ready_o;
  way_ind_t             bist_res_o;
  logic                 bist_eoc_o;
  logic                 wr_req_i;
  way_ind_t             wr_way_i;
  index_t               wr_index_i;
  tag_t                 wr_tag_i;
  logic                 lk_req_i;
  index_t               lk_index_i;
  logic [TagLength-1:0] lk_tag_i;
  logic                 lk_valid_o;
  way_ind_t             lk_hit_o;
  logic                 lk_dirty_o;
  logic                 func_ready_o;

  // reference contents of every way
  tag_t        model [NumWays][NumSets];
  // outstanding lookups, oldest first
  way_ind_t    exp_hit_q [$];
  logic        exp_dirty_q [$];
  int          issue_cyc_q [$];
  int          cycle_cnt;
  int          eoc_count;
  int          eoc_base;
  logic [31:0] rng_state;
  logic        bist_pending;

  llc_tag_store u_dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .bist_valid_i (bist_valid_i),
    .bist_ready_o (bist_ready_o),
    .bist_res_o   (bist_res_o),
    .bist_eoc_o   (bist_eoc_o),
    .wr_req_i     (wr_req_i),
    .wr_way_i     (wr_way_i),
    .wr_index_i   (wr_index_i),
    .wr_tag_i     (wr_tag_i),
    .lk_req_i     (lk_req_i),
    .lk_index_i   (lk_index_i),
    .lk_tag_i     (lk_tag_i),
    .lk_valid_o   (lk_valid_o),
    .lk_hit_o     (lk_hit_o),
    .lk_dirty_o   (lk_dirty_o),
    .func_ready_o (func_ready_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // cycle number, read before the edge updates it
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && bist_eoc_o === 1'b1) begin
      eoc_count <= eoc_count + 1;
    end
  end

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic fail_run(input string reason);
    $display("FAILURE at time %0t: %s", $time, reason);
    abort_run();
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // results come back in issue order
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1 && lk_valid_o !== 1'b0) begin
      if (issue_cyc_q.size() == 0) begin
        fail_run("lk_valid_o rose with no lookup outstanding");
      end else begin
        check_equal(cycle_cnt - issue_cyc_q[0], 2, "lookup latency in cycles");
        check_equal(lk_hit_o, exp_hit_q[0], "lk_hit_o");
        check_equal(lk_dirty_o, exp_dirty_q[0], "lk_dirty_o");
        void'(issue_cyc_q.pop_front());
        void'(exp_hit_q.pop_front());
        void'(exp_dirty_q.pop_front());
      end
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // a way hits when its entry is valid and the tag matches
  function automatic way_ind_t model_hits(input index_t idx, input logic [TagLength-1:0] tag);
    way_ind_t hits;
    hits = '0;
    for (int w = 0; w < NumWays; w++) begin
      hits[w] = model[w][idx].val && (model[w][idx].tag == tag);
    end
    return hits;
  endfunction

  function automatic logic model_dirty(input index_t idx, input logic [TagLength-1:0] tag);
    logic dirty;
    dirty = 1'b0;
    for (int w = 0; w < NumWays; w++) begin
      if (model[w][idx].val && (model[w][idx].tag == tag)) begin
        dirty = dirty | model[w][idx].dit;
      end
    end
    return dirty;
  endfunction

  // march x leaves every entry at zero
  task automatic clear_model();
    for (int w = 0; w < NumWays; w++) begin
      for (int s = 0; s < NumSets; s++) begin
        model[w][s] = '0;
      end
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    bist_valid_i <= 1'b0;
    wr_req_i     <= 1'b0;
    lk_req_i     <= 1'b0;
  endtask

  task automatic drive_write(input way_ind_t way, input index_t idx, input tag_t entry);
    @(posedge clk_i);
    lk_req_i   <= 1'b0;
    wr_req_i   <= 1'b1;
    wr_way_i   <= way;
    wr_index_i <= idx;
    wr_tag_i   <= entry;
    for (int w = 0; w < NumWays; w++) begin
      if (way[w]) begin
        model[w][idx] = entry;
      end
    end
  endtask

  task automatic issue_lookup(input index_t idx, input logic [TagLength-1:0] tag);
    way_ind_t hits;
    logic     dirty;
    hits  = model_hits(idx, tag);
    dirty = model_dirty(idx, tag);
    @(posedge clk_i);
    wr_req_i   <= 1'b0;
    lk_req_i   <= 1'b1;
    lk_index_i <= idx;
    lk_tag_i   <= tag;
    exp_hit_q.push_back(hits);
    exp_dirty_q.push_back(dirty);
    // cycle in which the dut sees the request
    issue_cyc_q.push_back(cycle_cnt + 1);
  endtask

  task automatic drain_lookups();
    int n;
    idle_cycle();
    n = 0;
    while (issue_cyc_q.size() != 0) begin
      if (n == 20) begin
        fail_run("lk_valid_o never arrived for an outstanding lookup");
      end else begin
        @(posedge clk_i);
        n++;
      end
    end
  endtask

  task automatic start_self_test();
    drain_lookups();
    @(negedge clk_i);
    check_equal(bist_ready_o, 1'b1, "bist_ready_o before start");
    check_equal(bist_res_o, way_ind_t'('1), "bist_res_o held since the last run");
    @(posedge clk_i);
    bist_valid_i <= 1'b1;
    @(posedge clk_i);
    bist_valid_i <= 1'b0;
    @(negedge clk_i);
    check_equal(func_ready_o, 1'b0, "func_ready_o during self test");
    check_equal(bist_ready_o, 1'b0, "bist_ready_o during self test");
    eoc_base     = eoc_count;
    bist_pending = 1'b1;
  endtask

  task automatic finish_self_test();
    int n;
    n = 0;
    while (eoc_count == eoc_base) begin
      if (n == 1000) begin
        fail_run("bist_eoc_o never pulsed at the end of the self test");
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
    // pulse is a single cycle and the result is all ones on healthy memory
    check_equal(bist_eoc_o, 1'b0, "bist_eoc_o after the pulse");
    check_equal(bist_ready_o, 1'b1, "bist_ready_o after self test");
    check_equal(func_ready_o, 1'b1, "func_ready_o after self test");
    check_equal(bist_res_o, way_ind_t'('1), "bist_res_o");
    bist_pending = 1'b0;
    clear_model();
    // filler lookups on cleared memory, back to back
    for (int i = 0; i < 6; i++) begin
      rng_state = xorshift32(rng_state);
      issue_lookup(rng_state[IndexLength-1:0], rng_state[IndexLength +: TagLength]);
    end
    drain_lookups();
    // no further end pulse once the run is over
    check_equal(eoc_count, eoc_base + 1, "number of bist_eoc_o pulses");
  endtask

  // both strobes must be dropped while the self test owns the ways
  task automatic offer_while_busy(input way_ind_t way, input index_t idx, input tag_t entry);
    if (!bist_pending) begin
      fail_run("an X line came with no self test running");
    end else begin
      @(negedge clk_i);
      check_equal(func_ready_o, 1'b0, "func_ready_o while busy");
      @(posedge clk_i);
      wr_req_i   <= 1'b1;
      wr_way_i   <= way;
      wr_index_i <= idx;
      wr_tag_i   <= entry;
      @(posedge clk_i);
      wr_req_i   <= 1'b0;
      lk_req_i   <= 1'b1;
      lk_index_i <= idx;
      lk_tag_i   <= entry.tag;
      @(posedge clk_i);
      lk_req_i   <= 1'b0;
      repeat (3) begin
        @(negedge clk_i);
        check_equal(lk_valid_o, 1'b0, "lk_valid_o for a lookup offered while busy");
      end
    end
  endtask

  initial begin
    int          fd;
    int          c;
    int          n_fields;
    logic [31:0] f_way, f_idx, f_val, f_dit, f_tag, f_hit, f_dirty;
    tag_t        entry;
    rst_n_i      <= 1'b0;
    bist_valid_i <= 1'b0;
    wr_req_i     <= 1'b0;
    wr_way_i     <= '0;
    wr_index_i   <= '0;
    wr_tag_i     <= '0;
    lk_req_i     <= 1'b0;
    lk_index_i   <= '0;
    lk_tag_i     <= '0;
    cycle_cnt    = 0;
    eoc_count    = 0;
    rng_state    = 32'h024d2534;
    bist_pending = 1'b0;
    clear_model();
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_equal(bist_ready_o, 1'b1, "bist_ready_o after reset");
    check_equal(bist_eoc_o, 1'b0, "bist_eoc_o after reset");
    check_equal(bist_res_o, way_ind_t'('1), "bist_res_o after reset");
    check_equal(lk_valid_o, 1'b0, "lk_valid_o after reset");

    fd = $fopen("sim/llc_tag_stim.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open sim/llc_tag_stim.txt");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        // comment runs to the end of the line
        while (c != "\n" && c != -1) begin
          c = $fgetc(fd);
        end
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        n_fields = $fscanf(fd, "%h %h %h %h %h %h %h",
                           f_way, f_idx, f_val, f_dit, f_tag, f_hit, f_dirty);
        if (n_fields != 7) begin
          fail_run("malformed line in the stimulus file");
        end
        entry.val = f_val[0];
        entry.dit = f_dit[0];
        entry.tag = f_tag[TagLength-1:0];
        // a running self test ends before any line but X
        if (bist_pending && c != "X") begin
          finish_self_test();
        end
        case (c)
          "B": start_self_test();
          "W": drive_write(f_way[NumWays-1:0], f_idx[IndexLength-1:0], entry);
          "L": begin
            check_equal(f_hit, model_hits(f_idx[IndexLength-1:0], entry.tag),
                        "stimulus file hit vector against the reference model");
            check_equal(f_dirty, model_dirty(f_idx[IndexLength-1:0], entry.tag),
                        "stimulus file dirty flag against the reference model");
            issue_lookup(f_idx[IndexLength-1:0], entry.tag);
          end
          "X": offer_while_busy(f_way[NumWays-1:0], f_idx[IndexLength-1:0], entry);
          default: fail_run("unknown opcode in the stimulus file");
        endcase
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    if (bist_pending) begin
      finish_self_test();
    end
    drain_lookups();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- sim/llc_tag_stim.txt
# opcode, then hex fields: way index val dirty tag exp_hit exp_dirty
# B self test, W write, L lookup, X write and lookup offered during a self test
B 0 00 0 0 000 0 0
L 0 05 0 0 123 0 0
L 0 1f 0 0 000 0 0
W 1 03 1 0 2a5 0 0
L 0 03 0 0 2a5 1 0
L 0 03 0 0 2a4 0 0
L 0 04 0 0 2a5 0 0
W 4 07 1 1 155 0 0
L 0 07 0 0 155 4 1
W 1 03 1 1 2a5 0 0
L 0 03 0 0 2a5 1 1
W 2 0a 1 0 3c3 0 0
W 4 0b 1 1 3c3 0 0
W 8 0c 1 0 3c3 0 0
L 0 0a 0 0 3c3 2 0
L 0 0b 0 0 3c3 4 1
L 0 0c 0 0 3c3 8 0
L 0 0d 0 0 3c3 0 0
W 8 10 0 1 0f0 0 0
L 0 10 0 0 0f0 0 0
B 0 00 0 0 000 0 0
X 1 03 1 0 2a5 0 0
X 2 15 1 1 111 0 0
L 0 03 0 0 2a5 0 0
L 0 07 0 0 155 0 0
L 0 0b 0 0 3c3 0 0
L 0 15 0 0 111 0 0
W 2 15 1 1 111 0 0
L 0 15 0 0 111 2 1

//--- files.f
logic/llc_tag_pkg.sv
logic/llc_index_counter.sv
logic/llc_tag_bist_ctrl.sv
logic/llc_tag_sram.sv
logic/llc_tag_port_mux.sv
logic/llc_tag_read_check.sv
logic/llc_tag_lookup.sv
logic/llc_tag_store.sv
sim/tb_llc_tag_store.sv

//--- Bender.yml
package:
  name: llc_tag_store

sources:
  - logic/llc_tag_pkg.sv
  - logic/llc_index_counter.sv
  - logic/llc_tag_bist_ctrl.sv
  - logic/llc_tag_sram.sv
  - logic/llc_tag_port_mux.sv
  - logic/llc_tag_read_check.sv
  - logic/llc_tag_lookup.sv
  - logic/llc_tag_store.sv
  - target: test
    files:
      - sim/tb_llc_tag_store.sv
